// File: hw/mipsPkg.sv
package mipsPkg;

	// architectural widths
	localparam int wordW = 32;
	localparam int regAddrW = 5;

	// boot vector in kseg1
	localparam logic [wordW-1:0] resetPc = 32'hBFC0_0000;

	// primary opcodes
	localparam logic [5:0] opSpecial = 6'h00;
	localparam logic [5:0] opJ       = 6'h02;
	localparam logic [5:0] opJal     = 6'h03;
	localparam logic [5:0] opBeq     = 6'h04;
	localparam logic [5:0] opBne     = 6'h05;
	localparam logic [5:0] opAddiu   = 6'h09;
	localparam logic [5:0] opSlti    = 6'h0A;
	localparam logic [5:0] opSltiu   = 6'h0B;
	localparam logic [5:0] opAndi    = 6'h0C;
	localparam logic [5:0] opOri     = 6'h0D;
	localparam logic [5:0] opXori    = 6'h0E;
	localparam logic [5:0] opLui     = 6'h0F;
	localparam logic [5:0] opLw      = 6'h23;
	localparam logic [5:0] opSw      = 6'h2B;

	// function codes under SPECIAL
	localparam logic [5:0] fnSll  = 6'h00;
	localparam logic [5:0] fnSrl  = 6'h02;
	localparam logic [5:0] fnSra  = 6'h03;
	localparam logic [5:0] fnJr   = 6'h08;
	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSubu = 6'h23;
	localparam logic [5:0] fnAnd  = 6'h24;
	localparam logic [5:0] fnOr   = 6'h25;
	localparam logic [5:0] fnXor  = 6'h26;
	localparam logic [5:0] fnNor  = 6'h27;
	localparam logic [5:0] fnSlt  = 6'h2A;
	localparam logic [5:0] fnSltu = 6'h2B;

	// decoded operation, immediate forms map onto the register forms
	typedef enum logic [4:0] {
		ADDU, SUBU, AND, OR, XOR, NOR, SLT, SLTU,
		SLL, SRL, SRA, LUI, LW, SW,
		BEQ, BNE, J, JAL, JR, RESERVED
	} aluOpT;

	// one instruction word, three field layouts
	typedef union packed {
		struct packed {
			logic [5:0] op;
			logic [regAddrW-1:0] rs;
			logic [regAddrW-1:0] rt;
			logic [regAddrW-1:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} rType;
		struct packed {
			logic [5:0] op;
			logic [regAddrW-1:0] rs;
			logic [regAddrW-1:0] rt;
			logic [15:0] imm;
		} iType;
		struct packed {
			logic [5:0] op;
			logic [25:0] target;
		} jType;
	} instrT;

endpackage

// File: hw/mainDecode.sv
`timescale 1ns/1ps

module mainDecode (
	input mipsPkg::instrT instr,
	output mipsPkg::aluOpT aluOp,
	output logic regWrite,
	output logic memRead,
	output logic memWrite,
	output logic aluSrcImm,
	output logic zeroExt,
	output logic branch,
	output logic jump,
	output logic link,
	output logic [mipsPkg::regAddrW-1:0] srcRegA,
	output logic [mipsPkg::regAddrW-1:0] srcRegB,
	output logic [mipsPkg::regAddrW-1:0] destReg,
	output logic exceptionRi
);

	always_comb begin
		logic immAlu;
		// defaults describe a reserved instruction
		immAlu = 1'b0;
		aluOp = mipsPkg::RESERVED;
		exceptionRi = 1'b1;
		regWrite = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		aluSrcImm = 1'b0;
		zeroExt = 1'b0;
		branch = 1'b0;
		jump = 1'b0;
		link = 1'b0;
		srcRegA = '0;
		srcRegB = '0;
		destReg = '0;
		case (instr.rType.op)
			mipsPkg::opSpecial: begin
				// register form, rd written by default
				exceptionRi = 1'b0;
				regWrite = 1'b1;
				srcRegA = instr.rType.rs;
				srcRegB = instr.rType.rt;
				destReg = instr.rType.rd;
				case (instr.rType.funct)
					mipsPkg::fnAddu: aluOp = mipsPkg::ADDU;
					mipsPkg::fnSubu: aluOp = mipsPkg::SUBU;
					mipsPkg::fnAnd:  aluOp = mipsPkg::AND;
					mipsPkg::fnOr:   aluOp = mipsPkg::OR;
					mipsPkg::fnXor:  aluOp = mipsPkg::XOR;
					mipsPkg::fnNor:  aluOp = mipsPkg::NOR;
					mipsPkg::fnSlt:  aluOp = mipsPkg::SLT;
					mipsPkg::fnSltu: aluOp = mipsPkg::SLTU;
					// shifts take only rt, amount from shamt
					mipsPkg::fnSll, mipsPkg::fnSrl, mipsPkg::fnSra: begin
						srcRegA = '0;
						if (instr.rType.funct == mipsPkg::fnSll)
							aluOp = mipsPkg::SLL;
						else if (instr.rType.funct == mipsPkg::fnSrl)
							aluOp = mipsPkg::SRL;
						else
							aluOp = mipsPkg::SRA;
					end
					mipsPkg::fnJr: begin
						// jump through rs, no writeback
						aluOp = mipsPkg::JR;
						jump = 1'b1;
						regWrite = 1'b0;
						srcRegB = '0;
						destReg = '0;
					end
					default: begin
						// unknown function code
						exceptionRi = 1'b1;
						regWrite = 1'b0;
						srcRegA = '0;
						srcRegB = '0;
						destReg = '0;
					end
				endcase
			end
			mipsPkg::opAddiu: begin
				aluOp = mipsPkg::ADDU;
				immAlu = 1'b1;
			end
			mipsPkg::opSlti: begin
				aluOp = mipsPkg::SLT;
				immAlu = 1'b1;
			end
			mipsPkg::opSltiu: begin
				aluOp = mipsPkg::SLTU;
				immAlu = 1'b1;
			end
			// logical immediates are zero extended
			mipsPkg::opAndi: begin
				aluOp = mipsPkg::AND;
				immAlu = 1'b1;
				zeroExt = 1'b1;
			end
			mipsPkg::opOri: begin
				aluOp = mipsPkg::OR;
				immAlu = 1'b1;
				zeroExt = 1'b1;
			end
			mipsPkg::opXori: begin
				aluOp = mipsPkg::XOR;
				immAlu = 1'b1;
				zeroExt = 1'b1;
			end
			mipsPkg::opLui: begin
				aluOp = mipsPkg::LUI;
				immAlu = 1'b1;
			end
			mipsPkg::opLw: begin
				aluOp = mipsPkg::LW;
				immAlu = 1'b1;
				memRead = 1'b1;
			end
			mipsPkg::opSw: begin
				// address from rs, store data from rt
				aluOp = mipsPkg::SW;
				exceptionRi = 1'b0;
				memWrite = 1'b1;
				aluSrcImm = 1'b1;
				srcRegA = instr.iType.rs;
				srcRegB = instr.iType.rt;
			end
			mipsPkg::opBeq, mipsPkg::opBne: begin
				aluOp = (instr.iType.op == mipsPkg::opBeq) ? mipsPkg::BEQ : mipsPkg::BNE;
				exceptionRi = 1'b0;
				branch = 1'b1;
				srcRegA = instr.iType.rs;
				srcRegB = instr.iType.rt;
			end
			mipsPkg::opJ: begin
				aluOp = mipsPkg::J;
				exceptionRi = 1'b0;
				jump = 1'b1;
			end
			mipsPkg::opJal: begin
				// return address goes to ra
				aluOp = mipsPkg::JAL;
				exceptionRi = 1'b0;
				jump = 1'b1;
				link = 1'b1;
				regWrite = 1'b1;
				destReg = 5'd31;
			end
			default: ;
		endcase
		// shared shape of immediate alu ops and loads
		if (immAlu) begin
			exceptionRi = 1'b0;
			regWrite = 1'b1;
			aluSrcImm = 1'b1;
			srcRegA = instr.iType.rs;
			destReg = instr.iType.rt;
		end
	end

	// reserved flag and reserved op come from separate paths above
	always_comb begin
		riMatch: assert final (exceptionRi == (aluOp == mipsPkg::RESERVED));
	end

endmodule

// File: hw/signalDecode.sv
`timescale 1ns/1ps

module signalDecode (
	input logic clk,
	input logic rstN,
	input logic fetchValid,
	input mipsPkg::instrT fetchInstr,
	input logic [mipsPkg::wordW-1:0] fetchPc,
	input logic [mipsPkg::wordW-1:0] fetchPcPlus4,
	input logic fetchExc,
	input logic decReady,
	output logic fetchReady,
	output logic decValid,
	output logic [mipsPkg::wordW-1:0] decPc,
	output logic [mipsPkg::wordW-1:0] decPcPlus4,
	output mipsPkg::aluOpT decAluOp,
	output logic decRegWrite,
	output logic decMemRead,
	output logic decMemWrite,
	output logic decAluSrcImm,
	output logic decBranch,
	output logic decJump,
	output logic decLink,
	output logic [mipsPkg::regAddrW-1:0] decSrcRegA,
	output logic [mipsPkg::regAddrW-1:0] decSrcRegB,
	output logic [mipsPkg::regAddrW-1:0] decDestReg,
	output logic [4:0] decShamt,
	output logic [mipsPkg::wordW-1:0] decExtImm,
	output logic [mipsPkg::wordW-1:0] decPcBranch,
	output logic [mipsPkg::wordW-1:0] decPcJump,
	output logic [mipsPkg::regAddrW-1:0] decCp0Addr,
	output logic [2:0] decCp0Sel,
	output logic decExceptionRi,
	output logic decExceptionInstr
);

	mipsPkg::aluOpT aluOp;
	logic regWrite, memRead, memWrite, aluSrcImm, zeroExt;
	logic branch, jump, link, exceptionRi;
	logic [mipsPkg::regAddrW-1:0] srcRegA, srcRegB, destReg;
	logic [mipsPkg::wordW-1:0] extImm, pcBranch, pcJump;
	logic load;

	mainDecode mainDecode_inst (
		.instr(fetchInstr),
		.aluOp(aluOp),
		.regWrite(regWrite),
		.memRead(memRead),
		.memWrite(memWrite),
		.aluSrcImm(aluSrcImm),
		.zeroExt(zeroExt),
		.branch(branch),
		.jump(jump),
		.link(link),
		.srcRegA(srcRegA),
		.srcRegB(srcRegB),
		.destReg(destReg),
		.exceptionRi(exceptionRi)
	);

	// zero or sign extension of the 16-bit immediate
	assign extImm = zeroExt ? {16'h0000, fetchInstr.iType.imm}
		: {{16{fetchInstr.iType.imm[15]}}, fetchInstr.iType.imm};
	// branch offset counts words from the delay slot
	assign pcBranch = fetchPcPlus4 + {extImm[29:0], 2'b00};
	// jump stays inside the current 256 MB region
	assign pcJump = {fetchPcPlus4[31:28], fetchInstr.jType.target, 2'b00};

	// output register empty or draining this cycle
	assign fetchReady = !decValid || decReady;
	assign load = fetchValid && fetchReady;

	always_ff @(posedge clk) begin
		if (!rstN)
			decValid <= 1'b0;
		else if (fetchReady)
			decValid <= fetchValid;
	end

	// payload only moves on an accepted item
	always_ff @(posedge clk) begin
		if (load) begin
			decPc <= fetchPc;
			decPcPlus4 <= fetchPcPlus4;
			decAluOp <= aluOp;
			decRegWrite <= regWrite;
			decMemRead <= memRead;
			decMemWrite <= memWrite;
			decAluSrcImm <= aluSrcImm;
			decBranch <= branch;
			decJump <= jump;
			decLink <= link;
			decSrcRegA <= srcRegA;
			decSrcRegB <= srcRegB;
			decDestReg <= destReg;
			decShamt <= fetchInstr.rType.shamt;
			decExtImm <= extImm;
			decPcBranch <= pcBranch;
			decPcJump <= pcJump;
			// cp0 register number sits in rd, select in the low bits
			decCp0Addr <= fetchInstr.rType.rd;
			decCp0Sel <= fetchInstr[2:0];
			decExceptionRi <= exceptionRi;
			decExceptionInstr <= fetchExc;
		end
	end

	// stalled item held intact until the consumer takes it
	decHold: assert property (@(posedge clk) disable iff (!rstN)
		decValid && !decReady |=> decValid && $stable({decPc, decPcPlus4, decAluOp,
		decRegWrite, decMemRead, decMemWrite, decAluSrcImm, decBranch, decJump, decLink,
		decSrcRegA, decSrcRegB, decDestReg, decShamt, decExtImm, decPcBranch, decPcJump,
		decCp0Addr, decCp0Sel, decExceptionRi, decExceptionInstr}));

endmodule

// File: hw/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit (
	input logic clk,
	input logic rstN,
	output logic wbCyc,
	output logic wbStb,
	output logic wbWe,
	output logic [mipsPkg::wordW-1:0] wbAdr,
	input logic [mipsPkg::wordW-1:0] wbDatI,
	input logic wbAck,
	input logic wbErr,
	output logic fetchValid,
	output mipsPkg::instrT fetchInstr,
	output logic [mipsPkg::wordW-1:0] fetchPc,
	output logic [mipsPkg::wordW-1:0] fetchPcPlus4,
	output logic fetchExc,
	input logic fetchReady
);

	// bus state, high while a read is outstanding
	logic busy;
	logic [mipsPkg::wordW-1:0] pc;
	logic [mipsPkg::wordW-1:0] pcNext;
	logic respond;
	logic bufFree;
	logic bufValid;

	assign pcNext = pc + 32'd4;
	// ack or err closes the cycle
	assign respond = busy && (wbAck || wbErr);
	// buffer empty now or handed over on this edge
	assign bufFree = !bufValid || fetchReady;

	// read-only master
	assign wbCyc = busy;
	assign wbStb = busy;
	assign wbWe = 1'b0;
	assign wbAdr = pc;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			busy <= 1'b0;
			pc <= mipsPkg::resetPc;
		end else if (respond) begin
			// drop cyc for a cycle, step to next word
			busy <= 1'b0;
			pc <= pcNext;
		end else if (!busy && bufFree) begin
			busy <= 1'b1;
		end
	end

	// buffer is always empty while a read is outstanding
	always_ff @(posedge clk) begin
		if (!rstN)
			bufValid <= 1'b0;
		else if (respond)
			bufValid <= 1'b1;
		else if (fetchReady)
			bufValid <= 1'b0;
	end

	// captured word, zero on a bus error decodes as a nop
	always_ff @(posedge clk) begin
		if (respond) begin
			fetchInstr <= wbErr ? '0 : wbDatI;
			fetchPc <= pc;
			fetchPcPlus4 <= pcNext;
			fetchExc <= wbErr;
		end
	end

	assign fetchValid = bufValid;

	// address held until the slave answers
	adrHold: assert property (@(posedge clk) disable iff (!rstN)
		wbStb && !wbAck && !wbErr |=> wbStb && $stable(wbAdr));

	// offered item stays until decode takes it
	validHold: assert property (@(posedge clk) disable iff (!rstN)
		fetchValid && !fetchReady |=> fetchValid);

endmodule

// File: hw/frontEnd.sv
`timescale 1ns/1ps

module frontEnd (
	input logic clk,
	input logic rstN,
	output logic wbCyc,
	output logic wbStb,
	output logic wbWe,
	output logic [mipsPkg::wordW-1:0] wbAdr,
	input logic [mipsPkg::wordW-1:0] wbDatI,
	input logic wbAck,
	input logic wbErr,
	input logic decReady,
	output logic decValid,
	output logic [mipsPkg::wordW-1:0] decPc,
	output logic [mipsPkg::wordW-1:0] decPcPlus4,
	output mipsPkg::aluOpT decAluOp,
	output logic decRegWrite,
	output logic decMemRead,
	output logic decMemWrite,
	output logic decAluSrcImm,
	output logic decBranch,
	output logic decJump,
	output logic decLink,
	output logic [mipsPkg::regAddrW-1:0] decSrcRegA,
	output logic [mipsPkg::regAddrW-1:0] decSrcRegB,
	output logic [mipsPkg::regAddrW-1:0] decDestReg,
	output logic [4:0] decShamt,
	output logic [mipsPkg::wordW-1:0] decExtImm,
	output logic [mipsPkg::wordW-1:0] decPcBranch,
	output logic [mipsPkg::wordW-1:0] decPcJump,
	output logic [mipsPkg::regAddrW-1:0] decCp0Addr,
	output logic [2:0] decCp0Sel,
	output logic decExceptionRi,
	output logic decExceptionInstr
);

	// fetch buffer to decode hand-off
	logic fetchValid, fetchReady, fetchExc;
	mipsPkg::instrT fetchInstr;
	logic [mipsPkg::wordW-1:0] fetchPc, fetchPcPlus4;

	fetchUnit fetchUnit_inst (
		.clk(clk),
		.rstN(rstN),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatI(wbDatI),
		.wbAck(wbAck),
		.wbErr(wbErr),
		.fetchValid(fetchValid),
		.fetchInstr(fetchInstr),
		.fetchPc(fetchPc),
		.fetchPcPlus4(fetchPcPlus4),
		.fetchExc(fetchExc),
		.fetchReady(fetchReady)
	);

	signalDecode signalDecode_inst (
		.clk(clk),
		.rstN(rstN),
		.fetchValid(fetchValid),
		.fetchInstr(fetchInstr),
		.fetchPc(fetchPc),
		.fetchPcPlus4(fetchPcPlus4),
		.fetchExc(fetchExc),
		.decReady(decReady),
		.fetchReady(fetchReady),
		.decValid(decValid),
		.decPc(decPc),
		.decPcPlus4(decPcPlus4),
		.decAluOp(decAluOp),
		.decRegWrite(decRegWrite),
		.decMemRead(decMemRead),
		.decMemWrite(decMemWrite),
		.decAluSrcImm(decAluSrcImm),
		.decBranch(decBranch),
		.decJump(decJump),
		.decLink(decLink),
		.decSrcRegA(decSrcRegA),
		.decSrcRegB(decSrcRegB),
		.decDestReg(decDestReg),
		.decShamt(decShamt),
		.decExtImm(decExtImm),
		.decPcBranch(decPcBranch),
		.decPcJump(decPcJump),
		.decCp0Addr(decCp0Addr),
		.decCp0Sel(decCp0Sel),
		.decExceptionRi(decExceptionRi),
		.decExceptionInstr(decExceptionInstr)
	);

endmodule

// File: tb/decodeModel.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// one expected output item, straight from the MIPS32 field rules
typedef struct packed {
	logic [31:0] pc;
	logic [31:0] pcPlus4;
	mipsPkg::aluOpT aluOp;
	logic regWrite;
	logic memRead;
	logic memWrite;
	logic aluSrcImm;
	logic branch;
	logic jump;
	logic link;
	logic [4:0] srcRegA;
	logic [4:0] srcRegB;
	logic [4:0] destReg;
	logic [4:0] shamt;
	logic [31:0] extImm;
	logic [31:0] pcBranch;
	logic [31:0] pcJump;
	logic [4:0] cp0Addr;
	logic [2:0] cp0Sel;
	logic exceptionRi;
	logic exceptionInstr;
} expItemT;

// operation from opcode and function code
function automatic mipsPkg::aluOpT opToAlu(input logic [5:0] op, input logic [5:0] fn);
	if (op == mipsPkg::opSpecial) begin
		case (fn)
			mipsPkg::fnSll: return mipsPkg::SLL;
			mipsPkg::fnSrl: return mipsPkg::SRL;
			mipsPkg::fnSra: return mipsPkg::SRA;
			mipsPkg::fnJr: return mipsPkg::JR;
			mipsPkg::fnAddu: return mipsPkg::ADDU;
			mipsPkg::fnSubu: return mipsPkg::SUBU;
			mipsPkg::fnAnd: return mipsPkg::AND;
			mipsPkg::fnOr: return mipsPkg::OR;
			mipsPkg::fnXor: return mipsPkg::XOR;
			mipsPkg::fnNor: return mipsPkg::NOR;
			mipsPkg::fnSlt: return mipsPkg::SLT;
			mipsPkg::fnSltu: return mipsPkg::SLTU;
			default: return mipsPkg::RESERVED;
		endcase
	end
	case (op)
		mipsPkg::opJ: return mipsPkg::J;
		mipsPkg::opJal: return mipsPkg::JAL;
		mipsPkg::opBeq: return mipsPkg::BEQ;
		mipsPkg::opBne: return mipsPkg::BNE;
		mipsPkg::opAddiu: return mipsPkg::ADDU;
		mipsPkg::opSlti: return mipsPkg::SLT;
		mipsPkg::opSltiu: return mipsPkg::SLTU;
		mipsPkg::opAndi: return mipsPkg::AND;
		mipsPkg::opOri: return mipsPkg::OR;
		mipsPkg::opXori: return mipsPkg::XOR;
		mipsPkg::opLui: return mipsPkg::LUI;
		mipsPkg::opLw: return mipsPkg::LW;
		mipsPkg::opSw: return mipsPkg::SW;
		default: return mipsPkg::RESERVED;
	endcase
endfunction

// full expected item for one bus word at address pc
function automatic expItemT modelDecode(input logic [31:0] word, input logic [31:0] pc,
	input logic err);
	expItemT e;
	logic [31:0] w;
	logic [5:0] op;
	logic immAlu;
	logic zeroExt;
	// a bus error turns the word into sll r0, r0, 0
	w = err ? 32'h0 : word;
	op = w[31:26];
	e = '0;
	e.pc = pc;
	e.pcPlus4 = pc + 32'd4;
	e.aluOp = opToAlu(op, w[5:0]);
	// addiu through lui sit at 0x09..0x0f
	immAlu = (op >= mipsPkg::opAddiu && op <= mipsPkg::opLui) || op == mipsPkg::opLw;
	// andi, ori, xori
	zeroExt = op >= mipsPkg::opAndi && op <= mipsPkg::opXori;
	if (e.aluOp == mipsPkg::RESERVED) begin
		e.exceptionRi = 1'b1;
	end else if (op == mipsPkg::opSpecial) begin
		if (e.aluOp == mipsPkg::JR) begin
			e.jump = 1'b1;
			e.srcRegA = w[25:21];
		end else begin
			e.regWrite = 1'b1;
			// shifts read rt only
			if (e.aluOp != mipsPkg::SLL && e.aluOp != mipsPkg::SRL && e.aluOp != mipsPkg::SRA)
				e.srcRegA = w[25:21];
			e.srcRegB = w[20:16];
			e.destReg = w[15:11];
		end
	end else if (immAlu) begin
		e.regWrite = 1'b1;
		e.aluSrcImm = 1'b1;
		e.memRead = op == mipsPkg::opLw;
		e.srcRegA = w[25:21];
		e.destReg = w[20:16];
	end else if (op == mipsPkg::opSw) begin
		e.memWrite = 1'b1;
		e.aluSrcImm = 1'b1;
		e.srcRegA = w[25:21];
		e.srcRegB = w[20:16];
	end else if (op == mipsPkg::opBeq || op == mipsPkg::opBne) begin
		e.branch = 1'b1;
		e.srcRegA = w[25:21];
		e.srcRegB = w[20:16];
	end else begin
		// j and jal
		e.jump = 1'b1;
		if (op == mipsPkg::opJal) begin
			e.link = 1'b1;
			e.regWrite = 1'b1;
			e.destReg = 5'd31;
		end
	end
	e.shamt = w[10:6];
	e.extImm = zeroExt ? {16'h0000, w[15:0]} : {{16{w[15]}}, w[15:0]};
	e.pcBranch = e.pcPlus4 + (e.extImm << 2);
	e.pcJump = {e.pcPlus4[31:28], w[25:0], 2'b00};
	e.cp0Addr = w[15:11];
	e.cp0Sel = w[2:0];
	e.exceptionInstr = err;
	return e;
endfunction

`endif

// File: tb/frontEndTb.sv
`timescale 1ns/1ps

module frontEndTb;

	localparam int clkPeriod = 40;
	localparam int itemTarget = 400;
	localparam int watchdogNs = itemTarget * 12 * clkPeriod;

	// encodings drawn for valid instructions
	localparam logic [5:0] fnList [0:11] = '{mipsPkg::fnSll, mipsPkg::fnSrl, mipsPkg::fnSra,
		mipsPkg::fnJr, mipsPkg::fnAddu, mipsPkg::fnSubu, mipsPkg::fnAnd, mipsPkg::fnOr,
		mipsPkg::fnXor, mipsPkg::fnNor, mipsPkg::fnSlt, mipsPkg::fnSltu};
	localparam logic [5:0] opList [0:12] = '{mipsPkg::opJ, mipsPkg::opJal, mipsPkg::opBeq,
		mipsPkg::opBne, mipsPkg::opAddiu, mipsPkg::opSlti, mipsPkg::opSltiu, mipsPkg::opAndi,
		mipsPkg::opOri, mipsPkg::opXori, mipsPkg::opLui, mipsPkg::opLw, mipsPkg::opSw};

	`include "decodeModel.svh"

	logic clk, rstN;
	logic wbCyc, wbStb, wbWe, wbAck, wbErr;
	logic [31:0] wbAdr, wbDatI;
	logic decReady, decValid;
	logic [31:0] decPc, decPcPlus4, decExtImm, decPcBranch, decPcJump;
	mipsPkg::aluOpT decAluOp;
	logic decRegWrite, decMemRead, decMemWrite, decAluSrcImm, decBranch, decJump, decLink;
	logic [4:0] decSrcRegA, decSrcRegB, decDestReg, decShamt, decCp0Addr;
	logic [2:0] decCp0Sel;
	logic decExceptionRi, decExceptionInstr;

	// lcg state and memory model state
	logic [31:0] seed;
	logic [31:0] busAdr;
	logic [31:0] respWord;
	logic respErr;
	logic pending;
	int waitLeft;
	int itemCount;
	expItemT expQ[$];

	frontEnd frontEnd_inst (
		.clk(clk),
		.rstN(rstN),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatI(wbDatI),
		.wbAck(wbAck),
		.wbErr(wbErr),
		.decReady(decReady),
		.decValid(decValid),
		.decPc(decPc),
		.decPcPlus4(decPcPlus4),
		.decAluOp(decAluOp),
		.decRegWrite(decRegWrite),
		.decMemRead(decMemRead),
		.decMemWrite(decMemWrite),
		.decAluSrcImm(decAluSrcImm),
		.decBranch(decBranch),
		.decJump(decJump),
		.decLink(decLink),
		.decSrcRegA(decSrcRegA),
		.decSrcRegB(decSrcRegB),
		.decDestReg(decDestReg),
		.decShamt(decShamt),
		.decExtImm(decExtImm),
		.decPcBranch(decPcBranch),
		.decPcJump(decPcJump),
		.decCp0Addr(decCp0Addr),
		.decCp0Sel(decCp0Sel),
		.decExceptionRi(decExceptionRi),
		.decExceptionInstr(decExceptionInstr)
	);

	always #(clkPeriod / 2) clk = ~clk;

	function automatic logic [31:0] nextRandom();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// one word in four fully random, the rest listed instructions
	function automatic logic [31:0] randomWord();
		logic [31:0] bits;
		int pick;
		bits = nextRandom();
		if (((nextRandom() >> 16) % 4) == 0)
			return bits;
		pick = (nextRandom() >> 16) % 25;
		if (pick < 12)
			return {mipsPkg::opSpecial, bits[25:6], fnList[pick]};
		return {opList[pick - 12], bits[25:0]};
	endfunction

	task automatic stopRun(input string why);
		$display("%s at %0t ns", why, $time);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic compareValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
			$display("Result: FAILED");
			$fatal(1);
		end
	endtask

	// wishbone slave with random wait states and errors
	task automatic serveBus();
		logic err;
		if (wbAck || wbErr) begin
			// response was taken on the last rising edge
			wbAck = 1'b0;
			wbErr = 1'b0;
			wbDatI = nextRandom();
			compareValue("wbCyc", wbCyc, 1'b0);
		end else if (wbCyc) begin
			compareValue("wbStb", wbStb, 1'b1);
			compareValue("wbWe", wbWe, 1'b0);
			// also holds the address steady across wait states
			compareValue("wbAdr", wbAdr, busAdr);
			if (!pending) begin
				pending = 1'b1;
				waitLeft = (nextRandom() >> 16) % 4;
				err = ((nextRandom() >> 16) % 16) == 0;
				respWord = randomWord();
				respErr = err;
				expQ.push_back(modelDecode(respWord, busAdr, err));
			end
			if (waitLeft == 0) begin
				pending = 1'b0;
				// data stays driven on error, the fetch must drop it
				wbDatI = respWord;
				wbAck = !respErr;
				wbErr = respErr;
				busAdr = busAdr + 32'd4;
			end else begin
				waitLeft--;
			end
		end else begin
			compareValue("wbStb", wbStb, 1'b0);
		end
	endtask

	task automatic checkItem(input expItemT e);
		compareValue("decPc", decPc, e.pc);
		compareValue("decPcPlus4", decPcPlus4, e.pcPlus4);
		compareValue("decAluOp", decAluOp, e.aluOp);
		compareValue("decRegWrite", decRegWrite, e.regWrite);
		compareValue("decMemRead", decMemRead, e.memRead);
		compareValue("decMemWrite", decMemWrite, e.memWrite);
		compareValue("decAluSrcImm", decAluSrcImm, e.aluSrcImm);
		compareValue("decBranch", decBranch, e.branch);
		compareValue("decJump", decJump, e.jump);
		compareValue("decLink", decLink, e.link);
		compareValue("decSrcRegA", decSrcRegA, e.srcRegA);
		compareValue("decSrcRegB", decSrcRegB, e.srcRegB);
		compareValue("decDestReg", decDestReg, e.destReg);
		compareValue("decShamt", decShamt, e.shamt);
		compareValue("decExtImm", decExtImm, e.extImm);
		compareValue("decPcBranch", decPcBranch, e.pcBranch);
		compareValue("decPcJump", decPcJump, e.pcJump);
		compareValue("decCp0Addr", decCp0Addr, e.cp0Addr);
		compareValue("decCp0Sel", decCp0Sel, e.cp0Sel);
		compareValue("decExceptionRi", decExceptionRi, e.exceptionRi);
		compareValue("decExceptionInstr", decExceptionInstr, e.exceptionInstr);
	endtask

	// random back-pressure, bundle checked before the edge that takes it
	task automatic consumeOutput();
		decReady = ((nextRandom() >> 16) % 10) >= 3;
		if (decValid && decReady) begin
			if (expQ.size() == 0)
				stopRun("decoded item came out with no bus word behind it");
			checkItem(expQ.pop_front());
			itemCount++;
		end
	endtask

	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		wbDatI = 32'h0;
		wbAck = 1'b0;
		wbErr = 1'b0;
		decReady = 1'b0;
		seed = 32'h2a26_760b;
		busAdr = mipsPkg::resetPc;
		respWord = 32'h0;
		respErr = 1'b0;
		pending = 1'b0;
		waitLeft = 0;
		itemCount = 0;
		repeat (5) @(negedge clk);
		// idle bus and empty output before release
		compareValue("wbCyc", wbCyc, 1'b0);
		compareValue("wbStb", wbStb, 1'b0);
		compareValue("decValid", decValid, 1'b0);
		rstN = 1'b1;
		@(negedge clk);
		// first read starts right after release
		compareValue("wbCyc", wbCyc, 1'b1);
		while (itemCount < itemTarget) begin
			serveBus();
			consumeOutput();
			@(negedge clk);
		end
		$display("Result: PASSED");
		$finish;
	end

	initial begin
		#(watchdogNs);
		stopRun("watchdog expired before all items were decoded");
	end

endmodule

// File: list.f
+incdir+tb
hw/mipsPkg.sv
hw/mainDecode.sv
hw/signalDecode.sv
hw/fetchUnit.sv
hw/frontEnd.sv
tb/frontEndTb.sv

// File: Bender.yml
package:
  name: mips_front_end

sources:
  # package first, then leaf modules, then the top level
  - hw/mipsPkg.sv
  - hw/mainDecode.sv
  - hw/signalDecode.sv
  - hw/fetchUnit.sv
  - hw/frontEnd.sv

  # testbench with its included model
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/frontEndTb.sv
